/* hw/snd_pkg.sv */
// shared types for the sound section
// cpu address map pages, adpcm register indexes
// oki adpcm step and index tables, mixer gain table
// fetch sequencer states

package snd_pkg;

    typedef logic [15:0]        cpu_addr_t;   // sound cpu address
    typedef logic [7:0]         cpu_data_t;   // sound cpu data byte
    typedef logic [15:0]        rom_addr_t;   // sample rom byte address
    typedef logic signed [11:0] adpcm_snd_t;  // decoded adpcm sample
    typedef logic signed [15:0] snd_t;        // audio sample
    typedef logic [7:0]         gain_t;       // 4.4 fixed point

    // pages are A[14:11], only with A[15] low
    localparam logic [3:0] PAGE_RAM    = 4'd0;
    localparam logic [3:0] PAGE_LATCH  = 4'd2;
    localparam logic [3:0] PAGE_STATUS = 4'd3;
    localparam logic [3:0] PAGE_FM     = 4'd5;
    localparam logic [3:0] PAGE_ADPCM  = 4'd7;

    // adpcm channel registers, A[2:1]
    localparam logic [1:0] REG_START = 2'd0;
    localparam logic [1:0] REG_END   = 2'd1;
    localparam logic [1:0] REG_PLAY  = 2'd2;
    localparam logic [1:0] REG_STOP  = 2'd3;

    // oki step sizes
    localparam logic [11:0] step_table [49] = '{
        12'd16,   12'd17,   12'd19,   12'd21,   12'd23,   12'd25,   12'd28,
        12'd31,   12'd34,   12'd37,   12'd41,   12'd45,   12'd50,   12'd55,
        12'd60,   12'd66,   12'd73,   12'd80,   12'd88,   12'd97,   12'd107,
        12'd118,  12'd130,  12'd143,  12'd157,  12'd173,  12'd190,  12'd209,
        12'd230,  12'd253,  12'd279,  12'd307,  12'd337,  12'd371,  12'd408,
        12'd449,  12'd494,  12'd544,  12'd598,  12'd658,  12'd724,  12'd796,
        12'd876,  12'd963,  12'd1060, 12'd1166, 12'd1282, 12'd1411, 12'd1552
    };

    // step index change, by nibble magnitude
    localparam logic signed [4:0] index_adjust [8] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd4, 5'sd6, 5'sd8
    };

    // low, medium, high, unity
    localparam gain_t gain_table [4] = '{8'h18, 8'h3f, 8'h5f, 8'h10};

    typedef enum logic [1:0] {
        IDLE,    // no sample playing
        FETCH,   // rom byte request
        HI_NIB,  // upper nibble pending
        LO_NIB   // lower nibble pending
    } voice_state_e;

endpackage

/* hw/snd_bus.sv */
// sound cpu bus glue
// page decode, adpcm register write strobes
// combinational read data mux, command interrupt flop

`timescale 1ns/100ps

module snd_bus (
    input  logic               clk,
    input  logic               rst_n,
    input  snd_pkg::cpu_addr_t addr,
    input  logic               rnw,
    input  snd_pkg::cpu_data_t cpu_dout,
    input  logic               bus_cen,     // access takes effect here
    input  logic               snd_irq,     // main board command strobe
    input  snd_pkg::cpu_data_t snd_latch,
    input  snd_pkg::cpu_data_t fm_dout,
    input  logic               busy0,
    input  logic               busy1,
    output snd_pkg::cpu_data_t cpu_din,
    output logic               irq_n,
    output logic               fm_cs,
    output logic               wr_en0,
    output logic               wr_en1,
    output logic [1:0]         reg_sel,
    output snd_pkg::cpu_data_t wr_data
);
    import snd_pkg::*;

    logic [3:0] page;
    logic       io_sel;      // A[15] low, rom space otherwise
    logic       latch_cs;
    logic       adpcm_cs;
    logic       adpcm_wr;
    logic       latch_rd;
    logic       irq_l;       // snd_irq last cycle

    assign page   = addr[14:11];
    assign io_sel = ~addr[15];

    assign latch_cs = io_sel && (page == PAGE_LATCH);
    assign fm_cs    = io_sel && (page == PAGE_FM);
    assign adpcm_cs = io_sel && (page == PAGE_ADPCM);

    // register writes, A[0] picks the channel
    assign adpcm_wr = adpcm_cs && bus_cen && !rnw;
    assign wr_en0   = adpcm_wr && !addr[0];
    assign wr_en1   = adpcm_wr &&  addr[0];
    assign reg_sel  = addr[2:1];
    assign wr_data  = cpu_dout;

    assign latch_rd = latch_cs && bus_cen && rnw;  // acknowledges irq

    always_comb begin
        cpu_din = 8'hff;  // unmapped
        if (io_sel) begin
            case (page)
                PAGE_RAM:    cpu_din = 8'hff;  // work ram not fitted here
                PAGE_LATCH:  cpu_din = snd_latch;
                PAGE_STATUS: cpu_din = {6'h3f, busy1, busy0};
                PAGE_FM:     cpu_din = fm_dout;
                default:     cpu_din = 8'hff;
            endcase
        end
    end

    // irq set on rising snd_irq, a new command beats the ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_l <= 1'b0;
            irq_n <= 1'b1;
        end else begin
            irq_l <= snd_irq;
            if (snd_irq && !irq_l) begin
                irq_n <= 1'b0;
            end else if (latch_rd) begin
                irq_n <= 1'b1;
            end
        end
    end

endmodule

/* hw/adpcm_regs.sv */
// adpcm channel register file
// start and end page registers
// play and stop command pulses, busy flag

`timescale 1ns/100ps

module adpcm_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  logic [1:0]         reg_sel,
    input  snd_pkg::cpu_data_t wr_data,
    input  logic               done,        // voice reached end page
    output snd_pkg::rom_addr_t start_addr,
    output snd_pkg::rom_addr_t end_addr,
    output logic               play,
    output logic               stop,
    output logic               busy
);
    import snd_pkg::*;

    cpu_data_t start_page;
    cpu_data_t end_page;
    logic      play_wr;
    logic      stop_wr;

    assign play_wr = wr_en && (reg_sel == REG_PLAY);
    assign stop_wr = wr_en && (reg_sel == REG_STOP);

    // pages are 256 bytes
    assign start_addr = {start_page, 8'h00};
    assign end_addr   = {end_page, 8'h00};  // exclusive

    always_ff @(posedge clk) begin
        if (wr_en && reg_sel == REG_START) start_page <= wr_data;
        if (wr_en && reg_sel == REG_END)   end_page   <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            play <= 1'b0;
            stop <= 1'b0;
            busy <= 1'b0;
        end else begin
            play <= play_wr;  // one cycle pulses to the voice
            stop <= stop_wr;
            if (stop_wr) begin
                busy <= 1'b0;
            end else if (play_wr) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

/* hw/adpcm_voice.sv */
// adpcm voice channel
// sample rom fetch sequencer, one byte per two nibbles
// oki 4 bit adpcm decoder with predictor and step index

`timescale 1ns/100ps

module adpcm_voice (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                oki_cen,     // nibble rate
    input  logic                play,
    input  logic                stop,
    input  snd_pkg::rom_addr_t  start_addr,
    input  snd_pkg::rom_addr_t  end_addr,
    output snd_pkg::rom_addr_t  rom_addr,
    output logic                rom_cs,
    input  snd_pkg::cpu_data_t  rom_data,
    input  logic                rom_ok,
    output logic                done,
    output snd_pkg::adpcm_snd_t snd
);
    import snd_pkg::*;

    voice_state_e      state;
    rom_addr_t         cur_addr;
    cpu_data_t         data_byte;   // byte being decoded
    adpcm_snd_t        pred;        // predictor, also the output
    logic [5:0]        idx;         // step index 0..48
    logic [3:0]        nib;
    logic [11:0]       step;
    logic [12:0]       diff;
    logic signed [13:0] pred_sum;
    adpcm_snd_t        pred_nx;
    logic signed [6:0] idx_sum;
    logic [5:0]        idx_nx;

    assign rom_addr = cur_addr;
    assign snd      = pred;

    assign nib  = (state == HI_NIB) ? data_byte[7:4] : data_byte[3:0];  // high first
    assign step = step_table[idx];

    always_comb begin
        diff = 13'(step >> 3);
        if (nib[2]) diff = diff + 13'(step);
        if (nib[1]) diff = diff + 13'(step >> 1);
        if (nib[0]) diff = diff + 13'(step >> 2);
        // bit 3 is the sign
        if (nib[3]) pred_sum = pred - $signed({1'b0, diff});
        else        pred_sum = pred + $signed({1'b0, diff});
        if (pred_sum > 14'sd2047)       pred_nx = 12'sh7ff;
        else if (pred_sum < -14'sd2048) pred_nx = 12'sh800;
        else                            pred_nx = pred_sum[11:0];
        idx_sum = $signed({1'b0, idx}) + index_adjust[nib[2:0]];
        if (idx_sum < 7'sd0)       idx_nx = 6'd0;
        else if (idx_sum > 7'sd48) idx_nx = 6'd48;
        else                       idx_nx = idx_sum[5:0];
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && rom_cs && rom_ok) data_byte <= rom_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            cur_addr <= '0;
            rom_cs   <= 1'b0;
            pred     <= '0;
            idx      <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (stop) begin
                state  <= IDLE;  // output silent at once
                rom_cs <= 1'b0;
                pred   <= '0;
            end else if (play) begin
                state    <= FETCH;
                cur_addr <= start_addr;
                rom_cs   <= 1'b0;
                pred     <= '0;
                idx      <= '0;
            end else begin
                case (state)
                    FETCH: begin
                        if (cur_addr == end_addr) begin
                            if (oki_cen) begin  // last nibble keeps its full slot
                                state <= IDLE;  // end page is exclusive
                                done  <= 1'b1;
                                pred  <= '0;
                            end
                        end else if (rom_cs && rom_ok) begin
                            rom_cs   <= 1'b0;  // byte in hand
                            cur_addr <= cur_addr + 16'd1;
                            state    <= HI_NIB;
                        end else begin
                            rom_cs <= 1'b1;  // wait on the rom
                        end
                    end
                    HI_NIB: if (oki_cen) begin
                        pred  <= pred_nx;
                        idx   <= idx_nx;
                        state <= LO_NIB;
                    end
                    LO_NIB: if (oki_cen) begin
                        pred  <= pred_nx;
                        idx   <= idx_nx;
                        state <= FETCH;  // late byte holds the sample
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* hw/snd_cen.sv */
// clock enables for the sound section
// adpcm nibble strobe and mixer strobe
// free running dividers

`timescale 1ns/100ps

module snd_cen #(
    parameter int OKI_DIV = 64,  // clk cycles per nibble
    parameter int MIX_DIV = 16   // clk cycles per mixer sample
) (
    input  logic clk,
    input  logic rst_n,
    output logic oki_cen,
    output logic mix_cen
);

    localparam int DIVS [2] = '{OKI_DIV, MIX_DIV};

    logic [1:0] cen;

    assign oki_cen = cen[0];
    assign mix_cen = cen[1];

    for (genvar i = 0; i < 2; i++) begin : g_div
        logic [15:0] cnt;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                cnt    <= '0;
                cen[i] <= 1'b0;
            end else begin
                cen[i] <= (cnt == 16'(DIVS[i] - 1));  // first pulse DIV cycles in
                cnt    <= (cnt == 16'(DIVS[i] - 1)) ? '0 : cnt + 16'd1;
            end
        end
    end

endmodule

/* hw/snd_mixer.sv */
// audio mixer
// adds fm and both adpcm voices, saturates
// applies 4.4 gain, saturates again, two stage pipeline

`timescale 1ns/100ps

module snd_mixer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mix_cen,
    input  snd_pkg::snd_t       fm_snd,
    input  snd_pkg::adpcm_snd_t snd0,
    input  snd_pkg::adpcm_snd_t snd1,
    input  logic [1:0]          vol_gain,
    output snd_pkg::snd_t       sound,
    output logic                sample
);
    import snd_pkg::*;

    snd_t               ext0;
    snd_t               ext1;
    logic signed [17:0] sum;     // headroom for three terms
    snd_t               sum_r;
    gain_t              gain_r;
    logic               vld1;    // stage one holds a sample
    logic signed [24:0] prod;

    // clip to 16 bits
    function automatic snd_t sat16(input logic signed [24:0] val);
        if (val > 25'sd32767)       return 16'sh7fff;
        else if (val < -25'sd32768) return 16'sh8000;
        else                        return val[15:0];
    endfunction

    assign ext0 = {snd0[11], snd0, 3'b000};  // x8
    assign ext1 = {snd1[11], snd1, 3'b000};
    assign sum  = fm_snd + ext0 + ext1;
    assign prod = sum_r * $signed({1'b0, gain_r});  // gain is unsigned

    always_ff @(posedge clk) begin
        if (mix_cen) begin
            sum_r  <= sat16(25'(sum));
            gain_r <= gain_table[vol_gain];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld1   <= 1'b0;
            sample <= 1'b0;
            sound  <= '0;
        end else begin
            vld1   <= mix_cen;
            sample <= vld1;  // marks new sound
            if (vld1) sound <= sat16(prod >>> 4);
        end
    end

endmodule

/* hw/snd_board.sv */
// sound board top level
// cpu bus glue, clock enables, two adpcm channels
// and the output mixer

`timescale 1ns/100ps

module snd_board #(
    parameter int OKI_DIV = 64,
    parameter int MIX_DIV = 16
) (
    // clock, cpu bus, command latch
    input  logic               clk,
    input  logic               rst_n,
    input  snd_pkg::cpu_addr_t addr,
    input  logic               rnw,
    input  snd_pkg::cpu_data_t cpu_dout,
    input  logic               bus_cen,
    output snd_pkg::cpu_data_t cpu_din,
    output logic               irq_n,
    input  logic               snd_irq,
    input  snd_pkg::cpu_data_t snd_latch,
    // fm chip and gain
    input  snd_pkg::snd_t      fm_snd,
    input  snd_pkg::cpu_data_t fm_dout,
    output logic               fm_cs,
    input  logic [1:0]         vol_gain,
    // sample roms
    output snd_pkg::rom_addr_t rom0_addr,
    output logic               rom0_cs,
    input  snd_pkg::cpu_data_t rom0_data,
    input  logic               rom0_ok,
    output snd_pkg::rom_addr_t rom1_addr,
    output logic               rom1_cs,
    input  snd_pkg::cpu_data_t rom1_data,
    input  logic               rom1_ok,
    // audio out
    output snd_pkg::snd_t      sound,
    output logic               sample
);
    import snd_pkg::*;

    logic       oki_cen, mix_cen;
    logic       wr_en0, wr_en1;
    logic [1:0] reg_sel;
    cpu_data_t  wr_data;
    rom_addr_t  start0, end0, start1, end1;
    logic       play0, stop0, busy0, done0;
    logic       play1, stop1, busy1, done1;
    adpcm_snd_t snd0, snd1;

    snd_bus u_bus (
        .clk, .rst_n, .addr, .rnw, .cpu_dout, .bus_cen, .snd_irq, .snd_latch,
        .fm_dout, .busy0, .busy1, .cpu_din, .irq_n, .fm_cs,
        .wr_en0, .wr_en1, .reg_sel, .wr_data
    );

    snd_cen #(.OKI_DIV(OKI_DIV), .MIX_DIV(MIX_DIV)) u_cen (
        .clk, .rst_n, .oki_cen, .mix_cen
    );

    adpcm_regs u_regs0 (
        .clk, .rst_n, .wr_en(wr_en0), .reg_sel, .wr_data, .done(done0),
        .start_addr(start0), .end_addr(end0), .play(play0), .stop(stop0), .busy(busy0)
    );

    adpcm_voice u_voice0 (
        .clk, .rst_n, .oki_cen, .play(play0), .stop(stop0),
        .start_addr(start0), .end_addr(end0),
        .rom_addr(rom0_addr), .rom_cs(rom0_cs), .rom_data(rom0_data), .rom_ok(rom0_ok),
        .done(done0), .snd(snd0)
    );

    adpcm_regs u_regs1 (
        .clk, .rst_n, .wr_en(wr_en1), .reg_sel, .wr_data, .done(done1),
        .start_addr(start1), .end_addr(end1), .play(play1), .stop(stop1), .busy(busy1)
    );

    adpcm_voice u_voice1 (
        .clk, .rst_n, .oki_cen, .play(play1), .stop(stop1),
        .start_addr(start1), .end_addr(end1),
        .rom_addr(rom1_addr), .rom_cs(rom1_cs), .rom_data(rom1_data), .rom_ok(rom1_ok),
        .done(done1), .snd(snd1)
    );

    snd_mixer u_mixer (
        .clk, .rst_n, .mix_cen, .fm_snd, .snd0, .snd1, .vol_gain, .sound, .sample
    );

endmodule

/* tests/tb_snd_board.sv */
// testbench for the sound board
// clock, reset, cpu bus tasks, two sample rom models with random latency
// reference adpcm decoder for channel 0, test file interpreter

`timescale 1ns/100ps

module tb_snd_board;
    import snd_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        rnw;
    logic        bus_cen;
    logic        snd_irq;
    logic        irq_n;
    logic        fm_cs;
    logic        sample;
    cpu_addr_t   addr;
    cpu_data_t   cpu_dout;
    cpu_data_t   cpu_din;
    cpu_data_t   snd_latch;
    cpu_data_t   fm_dout;
    snd_t        fm_snd;
    snd_t        sound;
    logic [1:0]  vol_gain;
    rom_addr_t   rom0_addr;
    rom_addr_t   rom1_addr;
    logic        rom0_cs;
    logic        rom1_cs;
    logic        rom0_ok;
    logic        rom1_ok;
    cpu_data_t   rom0_data;
    cpu_data_t   rom1_data;

    logic [7:0]  rom_mem [2][256];
    logic        ok_q [2];
    cpu_data_t   dat_q [2];
    logic        pend [2];      // request seen, byte not taken yet
    int          wait_c [2];    // cycles left before rom_ok
    int          exp_addr [2];  // next byte address the voice should ask for
    int          fetched [2];   // requests since the last play
    int          start_pg [2];
    int          end_pg [2];
    logic [31:0] lfsr = 32'h7149_968a;
    int          dec [0:599];   // channel 0 output after each nibble
    int          n_dec;
    int          dec_k;         // last nibble seen on sound
    logic        snd_chk = 1'b0;
    int          n_chk = 0;
    int          n_err = 0;
    int          n_oth = 0;
    int          steps [49] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73,
        80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279, 307,
        337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963, 1060, 1166,
        1282, 1411, 1552
    };

    assign rom0_ok   = ok_q[0];
    assign rom1_ok   = ok_q[1];
    assign rom0_data = dat_q[0];
    assign rom1_data = dat_q[1];

    always #50 clk = ~clk;  // 100 ns

    snd_board #(.OKI_DIV(8), .MIX_DIV(4)) u_snd_board (
        .clk, .rst_n, .addr, .rnw, .cpu_dout, .bus_cen, .cpu_din, .irq_n, .snd_irq,
        .snd_latch, .fm_snd, .fm_dout, .fm_cs, .vol_gain,
        .rom0_addr, .rom0_cs, .rom0_data, .rom0_ok,
        .rom1_addr, .rom1_cs, .rom1_data, .rom1_ok, .sound, .sample
    );

    task automatic check(input string name, input int act, input int exp);
        n_chk++;
        if (act !== exp) begin
            n_err++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, act, exp);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #5;  // just past the edge, outputs settled
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic fill_roms(input int k0, input int k1);
        for (int a = 0; a < 256; a++) begin
            rom_mem[0][a] = 8'((a * 37) ^ k0);  // odd multiplier, all address bits count
            rom_mem[1][a] = 8'((a * 37) ^ k1);
        end
    endtask

    // oki decoding of channel 0's byte range
    task automatic build_ref(input int first, input int last);
        int p;
        int ix;
        int st;
        int d;
        int nb;
        p      = 0;
        ix     = 0;
        n_dec  = 0;
        dec[0] = 0;
        for (int a = first; a < last && n_dec < 596; a++) begin
            for (int h = 1; h >= 0; h--) begin
                nb = (int'(rom_mem[0][a % 256]) >> (4 * h)) & 15;  // high nibble first
                st = steps[ix];
                d  = st / 8;
                if (nb & 4) d += st;
                if (nb & 2) d += st / 2;
                if (nb & 1) d += st / 4;
                if (nb & 8) d = -d;  // sign bit
                p = p + d;
                if (p > 2047) p = 2047;
                if (p < -2048) p = -2048;
                ix = ix + (((nb & 7) < 4) ? -1 : 2 * ((nb & 7) - 3));
                if (ix < 0) ix = 0;
                if (ix > 48) ix = 48;
                n_dec++;
                dec[n_dec] = p;
            end
        end
        n_dec++;
        dec[n_dec] = 0;  // silent past the end page
        dec_k      = 0;
    endtask

    task automatic bus_write(input int a, input int d);
        int ch;
        addr     = cpu_addr_t'(a);
        cpu_dout = cpu_data_t'(d);
        rnw      = 1'b0;
        bus_cen  = 1'b1;
        #1;
        if (a[15:11] == {1'b0, PAGE_ADPCM}) begin  // follow channel register writes
            ch = a & 1;
            case ((a >> 1) & 3)
                0: start_pg[ch] = d;
                1: end_pg[ch] = d;
                2: begin
                    exp_addr[ch] = start_pg[ch] * 256;
                    fetched[ch]  = 0;
                    if (ch == 0) build_ref(start_pg[0] * 256, end_pg[0] * 256);
                end
                default: ;
            endcase
        end
        tick();
        bus_cen = 1'b0;
        rnw     = 1'b1;
    endtask

    task automatic bus_read(input int a, output int val);
        addr    = cpu_addr_t'(a);
        rnw     = 1'b1;
        bus_cen = 1'b1;
        #1;
        val = int'(cpu_din);  // mid cycle, before the access edge
        tick();
        bus_cen = 1'b0;
    endtask

    task automatic raise_irq();
        int cyc;
        snd_irq = 1'b1;
        for (cyc = 0; cyc < 10 && irq_n; cyc++) tick();
        if (irq_n) begin
            n_oth++;
            $display("irq_n never went low after the command strobe");
        end
        snd_irq = 1'b0;
    endtask

    task automatic wait_bytes(input int n);
        int cyc;
        for (cyc = 0; cyc < 8000 && fetched[0] < n; cyc++) tick();
        if (fetched[0] < n) begin
            n_oth++;
            $display("channel 0 fetched only %0d of %0d bytes in time", fetched[0], n);
        end
    endtask

    task automatic wait_idle(input int ch, input int nbytes);
        int v;
        int cyc;
        v = 255;
        for (cyc = 0; cyc < 20000 && v[ch]; cyc++) bus_read({1'b0, PAGE_STATUS, 11'd0}, v);
        if (v[ch]) begin
            n_oth++;
            $display("channel %0d stayed busy past the time limit", ch);
        end else begin
            check("bytes_fetched", fetched[ch], nbytes);
        end
    endtask

    task automatic wait_samples(input int n);
        int seen;
        int cyc;
        seen = 0;
        for (cyc = 0; cyc < 100 && seen < n; cyc++) begin
            tick();
            if (sample) seen++;
        end
        if (seen < n) begin
            n_oth++;
            $display("mixer gave no sample pulse in time");
        end
    endtask

    // rom models, rom_ok after 0 to 3 random cycles
    always @(posedge clk) begin
        logic      cs;
        rom_addr_t ra;
        #5;
        for (int i = 0; i < 2; i++) begin
            cs = (i == 0) ? rom0_cs : rom1_cs;
            ra = (i == 0) ? rom0_addr : rom1_addr;
            if (!cs) begin
                pend[i] = 1'b0;
                ok_q[i] = 1'b0;
            end else if (!pend[i]) begin
                pend[i] = 1'b1;  // fresh request
                check((i == 0) ? "rom0_addr" : "rom1_addr", int'(ra), exp_addr[i]);
                exp_addr[i]++;
                fetched[i]++;
                draw_bits(2, wait_c[i]);
            end else if (wait_c[i] > 0) begin
                wait_c[i]--;
            end
            if (cs && wait_c[i] == 0) begin
                ok_q[i]  = 1'b1;
                dat_q[i] = rom_mem[i][ra[7:0]];
            end
        end
    end

    // sound against the reference, one nibble of lag allowed
    always @(posedge clk) begin
        #5;
        if (snd_chk && sample) begin
            if (dec_k < n_dec && int'(sound) == dec[dec_k + 1] * 8) dec_k++;
            check("sound", int'(sound), dec[dec_k] * 8);
        end
    end

    initial begin
        string      line;
        int         fd;
        int         a1;
        int         a2;
        int         a3;
        int         v;
        logic [7:0] op;
        rst_n     = 1'b0;
        addr      = '0;
        rnw       = 1'b1;
        cpu_dout  = '0;
        bus_cen   = 1'b0;
        snd_irq   = 1'b0;
        snd_latch = '0;
        fm_dout   = '0;
        fm_snd    = '0;
        vol_gain  = 2'd3;
        for (int i = 0; i < 2; i++) begin
            ok_q[i]     = 1'b0;
            dat_q[i]    = '0;
            pend[i]     = 1'b0;
            wait_c[i]   = 0;
            exp_addr[i] = 0;
            fetched[i]  = 0;
        end
        fill_roms(0, 0);
        repeat (10) tick();
        rst_n = 1'b1;
        fd = $fopen("tests/snd_tests.txt", "r");
        if (fd == 0) begin
            n_oth++;
            $display("could not open tests/snd_tests.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;
                op = line.getc(0);
                a1 = 0;
                a2 = 0;
                a3 = 0;
                void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a1, a2, a3));
                case (op)
                    "i": begin  // state right after reset
                        check("irq_n", irq_n, 1);
                        check("sound", int'(sound), 0);
                        check("rom0_cs", rom0_cs, 0);
                        check("rom1_cs", rom1_cs, 0);
                        check("sample", sample, 0);
                    end
                    "f": fill_roms(a1, a2);
                    "l": begin
                        snd_latch = cpu_data_t'(a1);
                        fm_dout   = cpu_data_t'(a2);
                    end
                    "r": begin
                        bus_read(a1, v);
                        check("cpu_din", v, a2);
                        // fm window is A15 low with page 5
                        check("fm_cs", fm_cs, int'(a1[15:11] == {1'b0, PAGE_FM}));
                    end
                    "w": bus_write(a1, a2);
                    "q": raise_irq();
                    "n": check("irq_n", irq_n, a1);
                    "t": wait_bytes(a1);
                    "d": wait_idle(a1, a2);
                    "c": begin
                        if (!a1[0]) begin
                            wait_samples(2);  // silent tail reaches the output
                            check("nibbles_seen", dec_k, n_dec);
                        end
                        snd_chk = a1[0];
                    end
                    "m": begin
                        fm_snd   = snd_t'(a1);
                        vol_gain = a2[1:0];
                        wait_samples(2);  // first pulse may still carry old inputs
                        check("sound", {16'd0, sound}, a3);
                    end
                    default: begin
                        n_oth++;
                        $display("unknown command %c in the test file", op);
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("checks %0d, mismatches %0d, other failures %0d", n_chk, n_err, n_oth);
        if (n_err == 0 && n_oth == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* tests/snd_tests.txt */
# op then up to three hex fields, op letters are i r w l q n f t d c m
# r addr expect, w addr data, l latch fm_dout, d chan bytes, m fm_snd gain expect
i
l 5a 3c
r 1800 fc
r 0000 ff
r 8000 ff
r 2800 3c
r 1000 5a
q
n 0
r 1000 5a
n 1
f 5b a7
w 3801 00
w 3803 01
w 3805 00
w 3800 00
w 3802 01
w 3804 00
r 1800 ff
t 40
w 3807 00
r 1800 fd
d 0 100
r 1800 fc
m 0000 3 0000
c 1
w 3804 00
d 0 100
c 0
# fm only, gain and both saturation limits
m 1000 3 1000
m 1000 0 1800
m 0100 1 03f0
m 2000 2 7fff
m e000 2 8000
m ffff 0 fffe
m 0003 1 000b
m 7fff 3 7fff
m 8000 0 8000
m 0800 1 1f80
m f800 0 f400

/* sim.f */
hw/snd_pkg.sv
hw/snd_bus.sv
hw/adpcm_regs.sv
hw/adpcm_voice.sv
hw/snd_cen.sv
hw/snd_mixer.sv
hw/snd_board.sv
tests/tb_snd_board.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the sound board testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_snd_board -f sim.f \
    || { echo "verilator build failed"; exit 1; }
out="$(./obj_dir/Vtb_snd_board)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '>>> PASS' && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
